/* Bender.yml */
package:
  name: motion_controller

sources:
  - verilog/motion_pkg.sv
  - verilog/command_decoder.sv
  - verilog/move_buffer.sv
  - verilog/move_sequencer.sv
  - verilog/dda_axis.sv
  - verilog/motion_controller.sv
  - target: test
    files:
      - testbench/tb_motion_controller.sv

/* all.f */
verilog/motion_pkg.sv
verilog/command_decoder.sv
verilog/move_buffer.sv
verilog/move_sequencer.sv
verilog/dda_axis.sv
verilog/motion_controller.sv
testbench/tb_motion_controller.sv

/* testbench/tb_motion_controller.sv */
// Runs with NUM_MOTORS 2, BUFFER_SIZE 2 and DEFAULT_DIVISOR 3; rates stay non-negative, moves last under 3000 cycles
`default_nettype none
`timescale 1ns/10ps

module tb_motion_controller;

  localparam int NUM_MOTORS      = 2;
  localparam int BUFFER_SIZE     = 2;
  localparam int DEFAULT_DIVISOR = 3;
  localparam int CLK_PERIOD      = 20;
  localparam int WORD_TIMEOUT    = 2000;  // Long enough to sit out one stalled move
  localparam int MOVE_TIMEOUT    = 3000;

  logic                      CLK;
  logic                      resetn;
  motion_pkg::word_t         word_data;
  logic                      word_valid;
  wire                       word_ready;
  wire motion_pkg::word_t    reply_data;
  wire [NUM_MOTORS-1:0]      step;
  wire [NUM_MOTORS-1:0]      dir;
  wire [NUM_MOTORS-1:0]      enable;
  wire [NUM_MOTORS-1:0]      brake;
  wire                       buffer_dtr;
  wire                       move_done;

  integer                    seed = 32'h9ab0;
  int                        error_count;
  int                        test_errors;
  int                        tests_run;
  int                        tests_failed;
  int                        stall_count;
  int                        step_count [NUM_MOTORS];
  int                        done_count;
  int                        dtr_low_cycles;
  int                        dir_mismatch;
  int                        base_steps [NUM_MOTORS];
  int                        base_done;
  int                        base_dtr;
  int                        base_mismatch;
  time                       accept_time;
  time                       last_done_time;
  logic [NUM_MOTORS-1:0]     expect_dir;
  logic [NUM_MOTORS-1:0]     move_dir;        // Fields of the next move to send
  motion_pkg::duration_t     move_duration;
  motion_pkg::dda_t          move_inc [NUM_MOTORS];
  motion_pkg::dda_t          move_acc [NUM_MOTORS];

  motion_controller #(
    .NUM_MOTORS(NUM_MOTORS), .BUFFER_SIZE(BUFFER_SIZE), .DEFAULT_DIVISOR(DEFAULT_DIVISOR)
  ) u_dut (
    .CLK(CLK), .resetn(resetn), .word_data(word_data), .word_valid(word_valid),
    .word_ready(word_ready), .reply_data(reply_data), .step(step), .dir(dir),
    .enable(enable), .brake(brake), .buffer_dtr(buffer_dtr), .move_done(move_done)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  // Event counters, sampled mid-cycle where every DUT output is settled
  always @(negedge CLK) begin
    if (!resetn) begin
      for (int i = 0; i < NUM_MOTORS; i++) begin
        if (step[i]) step_count[i]++;
      end
      if (move_done) begin
        done_count++;
        last_done_time = $time;
      end
      if (!buffer_dtr) dtr_low_cycles++;
      if (step != '0 && dir !== expect_dir) dir_mismatch++;
    end
  end

  task automatic check_word(input string what, input motion_pkg::word_t actual,
                            input motion_pkg::word_t expected);
    if (actual !== expected) begin
      $display("Error at %0d ns: %s is %h, expected %h", $time, what, actual, expected);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic check_bits(input string what, input logic [NUM_MOTORS-1:0] actual,
                            input logic [NUM_MOTORS-1:0] expected);
    if (actual !== expected) begin
      $display("Error at %0d ns: %s is %b, expected %b", $time, what, actual, expected);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic check_count(input string what, input int actual, input int expected);
    if (actual != expected) begin
      $display("Error at %0d ns: %s is %0d, expected %0d", $time, what, actual, expected);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic check_bound(input string what, input int actual, input int lo, input int hi);
    if (actual < lo || actual > hi) begin
      $display("Error at %0d ns: %s is %0d, expected %0d to %0d", $time, what, actual, lo, hi);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    $display("%s: %s", name, (test_errors == 0) ? "passed" : "failed");
    tests_run++;
    if (test_errors != 0) tests_failed++;
    test_errors = 0;
  endtask

  // Holds the word until a clock edge sees word_ready, then drops valid
  task automatic send_word(input motion_pkg::word_t w);
    int waited;
    waited = 0;
    @(negedge CLK);
    word_data  = w;
    word_valid = 1'b1;
    while (!word_ready && waited < WORD_TIMEOUT) begin
      stall_count++;
      @(negedge CLK);
      waited++;
    end
    if (!word_ready) begin
      $display("Timeout: word %h was not accepted within %0d cycles", w, WORD_TIMEOUT);
      error_count++;
      test_errors++;
    end else begin
      @(posedge CLK);
      accept_time = $time;
      @(negedge CLK);
    end
    word_valid = 1'b0;
  endtask

  task automatic send_move;
    send_word({motion_pkg::CMD_COORDINATED_STEP, 56'(move_dir)});
    send_word(64'(move_duration));
    for (int i = 0; i < NUM_MOTORS; i++) begin
      send_word(move_inc[i]);
      send_word(move_acc[i]);
    end
  endtask

  task automatic take_snapshot;
    @(posedge CLK);
    base_done     = done_count;
    base_dtr      = dtr_low_cycles;
    base_mismatch = dir_mismatch;
    for (int i = 0; i < NUM_MOTORS; i++) base_steps[i] = step_count[i];
  endtask

  task automatic wait_moves(input int moves);
    int waited;
    waited = 0;
    do begin
      @(posedge CLK);
      waited++;
    end while (done_count < base_done + moves && waited < MOVE_TIMEOUT);
    if (done_count < base_done + moves) begin
      $display("Timeout: move_done did not arrive within %0d cycles", MOVE_TIMEOUT);
      error_count++;
      test_errors++;
    end
  endtask

  // Rate k in 0..32, velocity is k * 2^58
  function automatic int draw_rate();
    return $unsigned($random(seed)) % 33;
  endfunction

  task automatic check_steps(input int expected [NUM_MOTORS]);
    for (int i = 0; i < NUM_MOTORS; i++) begin
      check_count($sformatf("axis %0d steps", i), step_count[i] - base_steps[i], expected[i]);
    end
    check_count("steps with wrong dir", dir_mismatch - base_mismatch, 0);
  endtask

  task automatic test_channel_info;
    send_word({motion_pkg::CMD_CHANNEL_INFO, 56'd0});
    check_word("channel info reply", reply_data, {40'd0, 8'd64, 8'(BUFFER_SIZE), 8'(NUM_MOTORS)});
    send_word('0);
    check_word("reply after zero word", reply_data, '0);
    finish_test("channel info");
  endtask

  task automatic test_enable_brake;
    logic [NUM_MOTORS-1:0] value;
    for (int n = 0; n < 3; n++) begin
      value = $random(seed);
      send_word({motion_pkg::CMD_MOTOR_ENABLE, 56'(value)});
      check_bits("enable", enable, value);
      value = $random(seed);
      send_word({motion_pkg::CMD_MOTOR_BRAKE, 56'(value)});
      check_bits("brake", brake, value);
    end
    finish_test("enable and brake");
  endtask

  task automatic test_constant_velocity;
    int expected [NUM_MOTORS];
    int k;
    take_snapshot();
    move_dir      = $random(seed);
    expect_dir    = move_dir;
    move_duration = 100;
    for (int i = 0; i < NUM_MOTORS; i++) begin
      k           = draw_rate();
      move_inc[i] = 64'(k) << 58;
      move_acc[i] = '0;
      expected[i] = (100 * k) / 64;
    end
    send_move();
    wait_moves(1);
    check_count("move_done pulses", done_count - base_done, 1);
    check_steps(expected);
    finish_test("constant velocity");
  endtask

  task automatic test_acceleration;
    int expected [NUM_MOTORS];
    logic [127:0] total;
    take_snapshot();
    move_dir      = $random(seed);
    expect_dir    = move_dir;
    move_duration = 60;
    for (int i = 0; i < NUM_MOTORS; i++) begin
      move_inc[i] = '0;
      move_acc[i] = 64'(($unsigned($random(seed)) % 8) + 1) << 54;
      total = '0;
      for (int n = 0; n < 60; n++) total = total + 128'(n) * {64'd0, move_acc[i]};
      expected[i] = int'(total >> 64);  // Whole carries out of the 64-bit accumulator
    end
    send_move();
    wait_moves(1);
    check_steps(expected);
    finish_test("acceleration");
  endtask

  task automatic test_divisor;
    int cycles;
    send_word({motion_pkg::CMD_CLK_DIVISOR, 56'd2});
    take_snapshot();
    move_dir      = '0;
    move_duration = 30;
    for (int i = 0; i < NUM_MOTORS; i++) begin
      move_inc[i] = '0;
      move_acc[i] = '0;
    end
    send_move();
    wait_moves(1);
    cycles = int'((last_done_time - accept_time) / CLK_PERIOD);
    check_bound("cycles from last word to move_done", cycles, 30 * 3, 30 * 3 + 8);
    send_word({motion_pkg::CMD_CLK_DIVISOR, 56'(DEFAULT_DIVISOR)});
    finish_test("divisor");
  endtask

  task automatic test_back_pressure;
    int expected [NUM_MOTORS];
    int k;
    int stalls;
    take_snapshot();
    stalls        = stall_count;
    move_dir      = $random(seed);
    expect_dir    = move_dir;
    move_duration = 200;
    for (int i = 0; i < NUM_MOTORS; i++) expected[i] = 0;
    for (int m = 0; m < 3; m++) begin
      for (int i = 0; i < NUM_MOTORS; i++) begin
        k           = draw_rate();
        move_inc[i] = 64'(k) << 58;
        move_acc[i] = '0;
        expected[i] += (200 * k) / 64;
      end
      send_move();
    end
    wait_moves(3);
    check_count("move_done pulses", done_count - base_done, 3);
    check_bound("word_ready stall cycles", stall_count - stalls, 1, WORD_TIMEOUT);
    check_bound("buffer_dtr low cycles", dtr_low_cycles - base_dtr, 1, 3 * MOVE_TIMEOUT);
    check_steps(expected);
    finish_test("back-pressure");
  endtask

  initial begin
    resetn     = 1'b1;
    word_data  = '0;
    word_valid = 1'b0;
    expect_dir = '0;
    repeat (10) @(posedge CLK);
    @(negedge CLK);
    resetn = 1'b0;
    test_channel_info();
    test_enable_brake();
    test_constant_velocity();
    test_acceleration();
    test_divisor();
    test_back_pressure();
    $display("Tests run: %0d, tests failed: %0d, errors: %0d", tests_run, tests_failed,
             error_count);
    if (error_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/command_decoder.sv */
// resetn is synchronous and active high; the last word of a move stalls while the buffer is full
`default_nettype none
`timescale 1ns/10ps

module command_decoder #(
  parameter int NUM_MOTORS      = 2,
  parameter int BUFFER_SIZE     = 2,
  parameter int DEFAULT_DIVISOR = 32
) (
  input  wire                         CLK,
  input  wire                         resetn,
  input  wire motion_pkg::word_t      word_data,
  input  wire                         word_valid,
  input  wire                         full,
  output wire                         word_ready,
  output motion_pkg::word_t           reply_data,
  output logic [NUM_MOTORS-1:0]       enable,
  output logic [NUM_MOTORS-1:0]       brake,
  output motion_pkg::divisor_t        divisor,
  output logic                        push,
  output logic [NUM_MOTORS-1:0]       entry_dir,
  output motion_pkg::duration_t       entry_duration,
  output motion_pkg::dda_t            entry_increment [NUM_MOTORS],
  output motion_pkg::dda_t            entry_accel [NUM_MOTORS]
);

  localparam int AXIS_BITS = (NUM_MOTORS > 1) ? $clog2(NUM_MOTORS) : 1;
  localparam logic [AXIS_BITS-1:0] LAST_AXIS = AXIS_BITS'(NUM_MOTORS - 1);

  motion_pkg::decoder_state_t state;
  logic [AXIS_BITS-1:0]       axis;      // Axis whose terms are arriving
  motion_pkg::header_t        header;
  motion_pkg::word_t          channel_info;
  wire                        last_word;
  wire                        accept;

  assign header = word_data[motion_pkg::WORD_BITS-1 -: 8];

  // Final accel word of a move is the only one that needs a free slot
  assign last_word  = (state == motion_pkg::move_accel) && (axis == LAST_AXIS);
  assign word_ready = !(last_word && full);
  assign accept     = word_valid && word_ready;

  assign channel_info = {40'd0, 8'(motion_pkg::DDA_BITS), 8'(BUFFER_SIZE), 8'(NUM_MOTORS)};

  always_ff @(posedge CLK) begin
    if (resetn) begin
      state      <= motion_pkg::idle_header;
      axis       <= '0;
      enable     <= '0;
      brake      <= '0;
      divisor    <= motion_pkg::divisor_t'(DEFAULT_DIVISOR);
      push       <= 1'b0;
      reply_data <= '0;
    end else begin
      push <= 1'b0;
      if (accept) begin
        reply_data <= '0;  // Only channel info answers with data
        case (state)
          motion_pkg::idle_header: begin
            case (header)
              motion_pkg::CMD_COORDINATED_STEP: state <= motion_pkg::move_duration;
              motion_pkg::CMD_MOTOR_ENABLE:     enable <= word_data[NUM_MOTORS-1:0];
              motion_pkg::CMD_MOTOR_BRAKE:      brake <= word_data[NUM_MOTORS-1:0];
              motion_pkg::CMD_CLK_DIVISOR:      divisor <= word_data[7:0];
              motion_pkg::CMD_CHANNEL_INFO:     reply_data <= channel_info;
              default:                          reply_data <= '0;  // Unknown header dropped
            endcase
          end
          motion_pkg::move_duration: begin
            axis  <= '0;
            state <= motion_pkg::move_increment;
          end
          motion_pkg::move_increment: begin
            state <= motion_pkg::move_accel;
          end
          motion_pkg::move_accel: begin
            if (axis == LAST_AXIS) begin
              push  <= 1'b1;  // Entry complete, hand it to the buffer
              state <= motion_pkg::idle_header;
            end else begin
              axis  <= axis + 1'b1;
              state <= motion_pkg::move_increment;
            end
          end
          default: state <= motion_pkg::idle_header;
        endcase
      end
    end
  end

  // Move being assembled
  always_ff @(posedge CLK) begin
    if (accept) begin
      case (state)
        motion_pkg::idle_header: begin
          if (header == motion_pkg::CMD_COORDINATED_STEP) begin
            entry_dir <= word_data[NUM_MOTORS-1:0];
          end
        end
        motion_pkg::move_duration:  entry_duration <= word_data[31:0];
        motion_pkg::move_increment: entry_increment[axis] <= word_data;
        motion_pkg::move_accel:     entry_accel[axis] <= word_data;
      endcase
    end
  end

  // The stall on the last word must keep every push clear of a full buffer
  push_not_full_a: assert property (@(posedge CLK) disable iff (resetn)
    push |-> !full);

endmodule

`default_nettype wire

/* verilog/dda_axis.sv */
// resetn is synchronous and active high; the accumulator treats velocity as unsigned, so use non-negative rates
`default_nettype none
`timescale 1ns/10ps

module dda_axis (
  input  wire                    CLK,
  input  wire                    resetn,
  input  wire                    dda_tick,
  input  wire                    loading,
  input  wire                    executing,
  input  wire motion_pkg::dda_t  increment,
  input  wire motion_pkg::dda_t  accel,
  output logic                   step
);

  localparam int DB = motion_pkg::DDA_BITS;

  motion_pkg::dda_t velocity;
  logic [DB-1:0]    accum;
  wire  [DB:0]      sum;       // Top bit is the carry out
  wire              advance;

  assign advance = dda_tick && executing;
  assign sum     = {1'b0, accum} + {1'b0, velocity};

  always_ff @(posedge CLK) begin
    if (loading) begin
      velocity <= increment;  // Start velocity of the move
      accum    <= '0;
    end else if (advance) begin
      accum    <= sum[DB-1:0];
      velocity <= velocity + accel;
    end
  end

  // Each carry is one step, seen the cycle after the tick
  always_ff @(posedge CLK) begin
    if (resetn) begin
      step <= 1'b0;
    end else begin
      step <= advance && sum[DB];
    end
  end

endmodule

`default_nettype wire

/* verilog/motion_controller.sv */
// resetn is synchronous and active high; NUM_MOTORS is 1 to 8 and BUFFER_SIZE is 2 or more
`default_nettype none
`timescale 1ns/10ps

module motion_controller #(
  parameter int NUM_MOTORS      = 2,
  parameter int BUFFER_SIZE     = 2,
  parameter int DEFAULT_DIVISOR = 32
) (
  input  wire                     CLK,
  input  wire                     resetn,
  input  wire motion_pkg::word_t  word_data,
  input  wire                     word_valid,
  output wire                     word_ready,
  output motion_pkg::word_t       reply_data,
  output wire [NUM_MOTORS-1:0]    step,
  output logic [NUM_MOTORS-1:0]   dir,
  output wire [NUM_MOTORS-1:0]    enable,
  output wire [NUM_MOTORS-1:0]    brake,
  output wire                     buffer_dtr,
  output wire                     move_done
);

  wire                        push;
  wire                        pop;
  wire                        full;
  wire                        empty;
  wire                        dda_tick;
  wire                        loading;
  wire                        executing;
  wire motion_pkg::divisor_t  divisor;
  wire [NUM_MOTORS-1:0]       entry_dir;
  wire [NUM_MOTORS-1:0]       head_dir;
  wire motion_pkg::duration_t entry_duration;
  wire motion_pkg::duration_t head_duration;
  wire motion_pkg::dda_t      entry_increment [NUM_MOTORS];
  wire motion_pkg::dda_t      entry_accel [NUM_MOTORS];
  wire motion_pkg::dda_t      head_increment [NUM_MOTORS];
  wire motion_pkg::dda_t      head_accel [NUM_MOTORS];

  command_decoder #(
    .NUM_MOTORS(NUM_MOTORS), .BUFFER_SIZE(BUFFER_SIZE), .DEFAULT_DIVISOR(DEFAULT_DIVISOR)
  ) u_decoder (
    .CLK(CLK), .resetn(resetn), .word_data(word_data), .word_valid(word_valid),
    .full(full), .word_ready(word_ready), .reply_data(reply_data), .enable(enable),
    .brake(brake), .divisor(divisor), .push(push), .entry_dir(entry_dir),
    .entry_duration(entry_duration), .entry_increment(entry_increment),
    .entry_accel(entry_accel)
  );

  move_buffer #(.NUM_MOTORS(NUM_MOTORS), .BUFFER_SIZE(BUFFER_SIZE)) u_buffer (
    .CLK(CLK), .resetn(resetn), .push(push), .entry_dir(entry_dir),
    .entry_duration(entry_duration), .entry_increment(entry_increment),
    .entry_accel(entry_accel), .pop(pop), .head_dir(head_dir),
    .head_duration(head_duration), .head_increment(head_increment),
    .head_accel(head_accel), .full(full), .empty(empty)
  );

  move_sequencer #(.DEFAULT_DIVISOR(DEFAULT_DIVISOR)) u_sequencer (
    .CLK(CLK), .resetn(resetn), .divisor(divisor), .empty(empty),
    .head_duration(head_duration), .dda_tick(dda_tick), .loading(loading),
    .executing(executing), .move_done(move_done), .pop(pop)
  );

  for (genvar i = 0; i < NUM_MOTORS; i++) begin : g_axis
    dda_axis u_axis (
      .CLK(CLK), .resetn(resetn), .dda_tick(dda_tick), .loading(loading),
      .executing(executing), .increment(head_increment[i]), .accel(head_accel[i]),
      .step(step[i])
    );
  end

  assign buffer_dtr = !full;

  // Set during load so dir is valid for the whole move, held between moves
  always_ff @(posedge CLK) begin
    if (resetn) begin
      dir <= '0;
    end else if (loading || executing) begin
      dir <= head_dir;
    end
  end

endmodule

`default_nettype wire

/* verilog/motion_pkg.sv */
// Host words are fixed at 64 bits; DDA terms are 64-bit signed fixed point with 64 fraction bits
`default_nettype none

package motion_pkg;

  localparam int WORD_BITS     = 64;
  localparam int DDA_BITS      = 64;  // Reported by channel info
  localparam int DURATION_BITS = 32;

  // One transfer in either direction
  typedef logic [WORD_BITS-1:0] word_t;

  // Command byte, word bits 63:56
  typedef logic [7:0] header_t;

  // Move length in DDA ticks
  typedef logic [DURATION_BITS-1:0] duration_t;

  // Velocity, acceleration and accumulator
  typedef logic signed [DDA_BITS-1:0] dda_t;

  // Tick period is divisor+1 clocks
  typedef logic [7:0] divisor_t;

  localparam header_t CMD_COORDINATED_STEP = 8'h01;
  localparam header_t CMD_MOTOR_ENABLE     = 8'h0a;
  localparam header_t CMD_MOTOR_BRAKE      = 8'h0b;
  localparam header_t CMD_CLK_DIVISOR      = 8'h20;
  localparam header_t CMD_CHANNEL_INFO     = 8'hfd;

  // Word position inside a coordinated move
  typedef enum logic [1:0] {
    idle_header,     // Expecting a command header
    move_duration,
    move_increment,
    move_accel
  } decoder_state_t;

  // Playback of the move at the buffer head
  typedef enum logic [1:0] {
    idle,
    load,      // Axes copy their start velocity
    execute,
    finish     // Pulses move_done and pop
  } sequencer_state_t;

endpackage

`default_nettype wire

/* verilog/move_buffer.sv */
// resetn is synchronous and active high; the writer must not push when full nor the reader pop when empty
`default_nettype none
`timescale 1ns/10ps

module move_buffer #(
  parameter int NUM_MOTORS  = 2,
  parameter int BUFFER_SIZE = 2
) (
  input  wire                         CLK,
  input  wire                         resetn,
  input  wire                         push,
  input  wire [NUM_MOTORS-1:0]        entry_dir,
  input  wire motion_pkg::duration_t  entry_duration,
  input  wire motion_pkg::dda_t       entry_increment [NUM_MOTORS],
  input  wire motion_pkg::dda_t       entry_accel [NUM_MOTORS],
  input  wire                         pop,
  output wire [NUM_MOTORS-1:0]        head_dir,
  output motion_pkg::duration_t       head_duration,
  output motion_pkg::dda_t            head_increment [NUM_MOTORS],
  output motion_pkg::dda_t            head_accel [NUM_MOTORS],
  output logic                        full,
  output logic                        empty
);

  localparam int PTR_BITS   = $clog2(BUFFER_SIZE);
  localparam int COUNT_BITS = $clog2(BUFFER_SIZE + 1);
  localparam logic [PTR_BITS-1:0] LAST_SLOT = PTR_BITS'(BUFFER_SIZE - 1);

  logic [NUM_MOTORS-1:0] mem_dir [BUFFER_SIZE];
  motion_pkg::duration_t mem_duration [BUFFER_SIZE];
  motion_pkg::dda_t      mem_increment [BUFFER_SIZE][NUM_MOTORS];
  motion_pkg::dda_t      mem_accel [BUFFER_SIZE][NUM_MOTORS];
  logic [PTR_BITS-1:0]   wr_ptr;
  logic [PTR_BITS-1:0]   rd_ptr;
  logic [COUNT_BITS-1:0] count;       // Moves held
  logic [COUNT_BITS-1:0] count_next;

  always_comb begin
    count_next = count;
    if (push && !pop) begin
      count_next = count + 1'b1;
    end else if (pop && !push) begin
      count_next = count - 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      full   <= 1'b0;
      empty  <= 1'b1;
    end else begin
      if (push) wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
      if (pop) rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
      count <= count_next;
      full  <= (count_next == COUNT_BITS'(BUFFER_SIZE));
      empty <= (count_next == '0);
    end
  end

  always_ff @(posedge CLK) begin
    if (push) begin
      mem_dir[wr_ptr]       <= entry_dir;
      mem_duration[wr_ptr]  <= entry_duration;
      mem_increment[wr_ptr] <= entry_increment;
      mem_accel[wr_ptr]     <= entry_accel;
    end
  end

  // Oldest move, read straight from the slot
  assign head_dir       = mem_dir[rd_ptr];
  assign head_duration  = mem_duration[rd_ptr];
  assign head_increment = mem_increment[rd_ptr];
  assign head_accel     = mem_accel[rd_ptr];

  no_overflow_a: assert property (@(posedge CLK) disable iff (resetn) full |-> !push);
  no_underflow_a: assert property (@(posedge CLK) disable iff (resetn) empty |-> !pop);

endmodule

`default_nettype wire

/* verilog/move_sequencer.sv */
// resetn is synchronous and active high; a new divisor takes effect at the next tick reload
`default_nettype none
`timescale 1ns/10ps

module move_sequencer #(
  parameter int DEFAULT_DIVISOR = 32
) (
  input  wire                         CLK,
  input  wire                         resetn,
  input  wire motion_pkg::divisor_t   divisor,
  input  wire                         empty,
  input  wire motion_pkg::duration_t  head_duration,
  output logic                        dda_tick,
  output wire                         loading,
  output wire                         executing,
  output wire                         move_done,
  output wire                         pop
);

  localparam int DW = $bits(motion_pkg::duration_t);

  motion_pkg::divisor_t         tick_count;
  motion_pkg::sequencer_state_t state;
  motion_pkg::duration_t        ticks_done;  // Ticks played of the current move
  wire [DW:0]                   ticks_next;
  wire                          last_tick;

  // Down counter reloads from divisor, one tick per divisor+1 clocks
  always_ff @(posedge CLK) begin
    if (resetn) begin
      tick_count <= motion_pkg::divisor_t'(DEFAULT_DIVISOR);
      dda_tick   <= 1'b0;
    end else if (tick_count == '0) begin
      tick_count <= divisor;
      dda_tick   <= 1'b1;
    end else begin
      tick_count <= tick_count - 1'b1;
      dda_tick   <= 1'b0;
    end
  end

  // Zero duration still plays a single tick
  assign ticks_next = {1'b0, ticks_done} + 1'b1;
  assign last_tick  = ticks_next >= {1'b0, head_duration};

  always_ff @(posedge CLK) begin
    if (resetn) begin
      state      <= motion_pkg::idle;
      ticks_done <= '0;
    end else begin
      case (state)
        motion_pkg::idle: begin
          if (!empty) state <= motion_pkg::load;
        end
        motion_pkg::load: begin
          ticks_done <= '0;
          state      <= motion_pkg::execute;
        end
        motion_pkg::execute: begin
          if (dda_tick) begin
            ticks_done <= ticks_next[DW-1:0];
            if (last_tick) state <= motion_pkg::finish;
          end
        end
        motion_pkg::finish: state <= motion_pkg::idle;
        default:            state <= motion_pkg::idle;
      endcase
    end
  end

  assign loading   = (state == motion_pkg::load);
  assign executing = (state == motion_pkg::execute);
  assign move_done = (state == motion_pkg::finish);
  assign pop       = (state == motion_pkg::finish);  // Release the slot as the move ends

  // The head move must not change under the sequencer while it plays
  head_stable_a: assert property (@(posedge CLK) disable iff (resetn)
    executing |-> $stable(head_duration));

endmodule

`default_nettype wire
